// ==== src/vregpack_pkg.sv ====
// vector register result packer shared definitions
// default widths, element width encoding and derived counts
`default_nettype none

package vregpack_pkg;

    // default configuration, overridable through the top level parameters
    localparam int unsigned VPORT_W_DEF    = 64;  // vreg file port width
    localparam int unsigned RES_W_DEF      = 32;  // result beat width
    localparam int unsigned VADDR_W_DEF    = 5;   // vreg address width
    localparam int unsigned INSTR_ID_W_DEF = 3;   // instruction id width

    // derived from the defaults
    localparam int unsigned VREG_CNT_DEF     = 1 << VADDR_W_DEF;     // registers
    localparam int unsigned INSTR_ID_CNT_DEF = 1 << INSTR_ID_W_DEF;  // ids in flight
    localparam int unsigned VPORT_BE_W_DEF   = VPORT_W_DEF / 8;      // write byte enables
    localparam int unsigned RES_BE_W_DEF     = RES_W_DEF / 8;        // beat byte enables

    // element width of the incoming result
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } sew_e;

endpackage

`default_nettype wire

// ==== src/pack_if.sv ====
// pack stage to write control link
// carries the staged instruction and buffers one way, advance the other way
`timescale 1ns/1ns
`default_nettype none

interface pack_if #(
    parameter int unsigned VPORT_W    = 64,
    parameter int unsigned VADDR_W    = 5,
    parameter int unsigned INSTR_ID_W = 3
);

    logic                  valid;     // stage holds an instruction
    logic [INSTR_ID_W-1:0] instr_id;
    logic [VADDR_W-1:0]    vaddr;     // destination register
    logic                  store;     // write buffer after this beat
    logic                  done;      // last beat of the instruction
    logic [VPORT_W-1:0]    data;      // data shift buffer
    logic [VPORT_W/8-1:0]  be;        // byte enable shift buffer
    logic                  advance;   // stage contents leave this cycle

    modport stage (
        output valid, instr_id, vaddr, store, done, data, be,
        input  advance
    );

    modport write (
        input  valid, instr_id, vaddr, store, done, data, be,
        output advance
    );

endinterface

`default_nettype wire

// ==== src/result_narrow.sv ====
// result narrowing
// turns an incoming beat into the value shifted into the pack buffer,
// halving element width with optional signed or unsigned saturation
`timescale 1ns/1ns
`default_nettype none

module result_narrow import vregpack_pkg::*; #(
    parameter int unsigned RES_W = 32
) (
    input  sew_e               eew_i,         // source element width
    input  logic [RES_W-1:0]   data_i,
    input  logic [RES_W/8-1:0] be_i,
    input  logic               narrow_i,
    input  logic               saturate_i,
    input  logic               signed_i,
    output logic [RES_W-1:0]   shift_data_o,
    output logic [RES_W/8-1:0] shift_be_o,
    output logic               saturated_o    // some element was clamped
);

    logic [RES_W/2-1:0]  narrow_data;  // packed half width elements
    logic [RES_W/16-1:0] narrow_be;
    logic                narrow_sat;

    always_comb begin
        narrow_data = '0;
        narrow_be   = '0;
        narrow_sat  = 1'b0;
        case (eew_i)
            SEW_16: begin
                for (int j = 0; j < RES_W / 16; j++) begin
                    narrow_data[j*8 +: 8] = data_i[j*16 +: 8];
                    narrow_be[j]          = be_i[j*2];  // lowest byte of the source element
                    // upper byte must be a plain extension of the kept byte
                    if (saturate_i &&
                        data_i[j*16+8 +: 8] != {8{signed_i & data_i[j*16+7]}}) begin
                        narrow_data[j*8 +: 8] = signed_i ?
                            {data_i[j*16+15], {7{~data_i[j*16+15]}}} : 8'hff;
                        narrow_sat = 1'b1;
                    end
                end
            end
            SEW_32: begin
                for (int j = 0; j < RES_W / 32; j++) begin
                    narrow_data[j*16 +: 16] = data_i[j*32 +: 16];
                    narrow_be[j*2 +: 2]     = {2{be_i[j*4]}};
                    if (saturate_i &&
                        data_i[j*32+16 +: 16] != {16{signed_i & data_i[j*32+15]}}) begin
                        // clamp to max or min by source sign
                        narrow_data[j*16 +: 16] = signed_i ?
                            {data_i[j*32+31], {15{~data_i[j*32+31]}}} : 16'hffff;
                        narrow_sat = 1'b1;
                    end
                end
            end
            default: ;  // no narrowing from 8 bit elements, nothing enabled
        endcase
    end

    // narrowed value sits in the upper half, the stage only takes that part
    assign shift_data_o = narrow_i ? {narrow_data, {(RES_W/2){1'b0}}} : data_i;
    assign shift_be_o   = narrow_i ? {narrow_be, {(RES_W/16){1'b0}}} : be_i;
    assign saturated_o  = narrow_i & narrow_sat;

endmodule

`default_nettype wire

// ==== src/pack_stage.sv ====
// pack stage
// single pipeline register for the instruction control fields, plus the
// data and byte enable shift buffers that collect result beats
`timescale 1ns/1ns
`default_nettype none

module pack_stage #(
    parameter int unsigned VPORT_W    = 64,
    parameter int unsigned RES_W      = 32,
    parameter int unsigned VADDR_W    = 5,
    parameter int unsigned INSTR_ID_W = 3
) (
    input  logic                  clk_i,
    input  logic                  async_rst_ni,

    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  logic [INSTR_ID_W-1:0] in_instr_id_i,
    input  logic [VADDR_W-1:0]    in_vaddr_i,
    input  logic                  in_store_i,
    input  logic                  in_res_valid_i,   // beat carries data
    input  logic                  in_narrow_i,
    input  logic                  in_done_i,
    input  logic [RES_W-1:0]      shift_data_i,     // from the narrowing logic
    input  logic [RES_W/8-1:0]    shift_be_i,

    pack_if.stage                 pif
);

    logic                  valid_q;
    logic [INSTR_ID_W-1:0] instr_id_q;
    logic [VADDR_W-1:0]    vaddr_q;
    logic                  store_q;
    logic                  done_q;
    logic [VPORT_W-1:0]    data_buf_q, data_buf_d;
    logic [VPORT_W/8-1:0]  be_buf_q, be_buf_d;
    logic                  accept;

    // stage can take a beat when empty or when its contents leave
    assign in_ready_o = ~valid_q | pif.advance;
    assign accept     = in_valid_i & in_ready_o;

    // buffers shift right, new data enters on top
    always_comb begin
        if (in_narrow_i) begin
            data_buf_d = {shift_data_i[RES_W-1 -: RES_W/2], data_buf_q[VPORT_W-1 : RES_W/2]};
            be_buf_d   = {shift_be_i[RES_W/8-1 -: RES_W/16], be_buf_q[VPORT_W/8-1 : RES_W/16]};
        end else begin
            data_buf_d = {shift_data_i, data_buf_q[VPORT_W-1 : RES_W]};
            be_buf_d   = {shift_be_i, be_buf_q[VPORT_W/8-1 : RES_W/8]};
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q    <= 1'b0;
            instr_id_q <= '0;
            vaddr_q    <= '0;
            store_q    <= 1'b0;
            done_q     <= 1'b0;
            data_buf_q <= '0;
            be_buf_q   <= '0;
        end else begin
            if (in_ready_o) begin
                valid_q <= in_valid_i;  // empties when nothing follows
            end
            if (accept) begin
                instr_id_q <= in_instr_id_i;
                vaddr_q    <= in_vaddr_i;
                store_q    <= in_store_i;
                done_q     <= in_done_i;
                if (in_res_valid_i) begin
                    data_buf_q <= data_buf_d;
                    be_buf_q   <= be_buf_d;
                end
            end
        end
    end

    assign pif.valid    = valid_q;
    assign pif.instr_id = instr_id_q;
    assign pif.vaddr    = vaddr_q;
    assign pif.store    = store_q;
    assign pif.done     = done_q;
    assign pif.data     = data_buf_q;
    assign pif.be       = be_buf_q;

endmodule

`default_nettype wire

// ==== src/vreg_write_ctrl.sv ====
// register file write control
// holds stores back on read or speculation hazards, drops writes of killed
// instructions and reports instruction completion
`timescale 1ns/1ns
`default_nettype none

module vreg_write_ctrl #(
    parameter int unsigned VPORT_W    = 64,
    parameter int unsigned VADDR_W    = 5,
    parameter int unsigned INSTR_ID_W = 3
) (
    pack_if.write                         pif,

    input  logic [(1 << VADDR_W)-1:0]     pending_reads_i,  // per register
    input  logic [(1 << INSTR_ID_W)-1:0]  instr_spec_i,     // per id
    input  logic [(1 << INSTR_ID_W)-1:0]  instr_killed_i,
    input  logic                          vreg_wr_ready_i,

    output logic                          vreg_wr_valid_o,
    output logic [VADDR_W-1:0]            vreg_wr_addr_o,
    output logic [VPORT_W-1:0]            vreg_wr_data_o,
    output logic [VPORT_W/8-1:0]          vreg_wr_be_o,
    output logic                          done_valid_o,
    output logic [INSTR_ID_W-1:0]         done_id_o
);

    logic stall;
    logic killed;

    // a store waits until its register is no longer read and its id is resolved
    assign stall  = pif.store &
                    (pending_reads_i[pif.vaddr] | instr_spec_i[pif.instr_id]);
    assign killed = instr_killed_i[pif.instr_id];

    // killed stores still advance, they just never reach the register file
    assign pif.advance = pif.valid & ~stall & (~pif.store | killed | vreg_wr_ready_i);

    assign vreg_wr_valid_o = pif.valid & pif.store & ~stall & ~killed;
    assign vreg_wr_addr_o  = pif.vaddr;
    assign vreg_wr_data_o  = pif.data;
    assign vreg_wr_be_o    = pif.be;

    assign done_valid_o = pif.advance & pif.done;  // one pulse per done beat
    assign done_id_o    = pif.instr_id;

endmodule

`default_nettype wire

// ==== src/vregpack_top.sv ====
// vector register result packer top level
// narrows incoming result beats, packs them into a register wide buffer
// and writes it to the register file with byte enables
`timescale 1ns/1ns
`default_nettype none

module vregpack_top import vregpack_pkg::*; #(
    parameter int unsigned VPORT_W    = VPORT_W_DEF,
    parameter int unsigned RES_W      = RES_W_DEF,
    parameter int unsigned VADDR_W    = VADDR_W_DEF,
    parameter int unsigned INSTR_ID_W = INSTR_ID_W_DEF
) (
    input  logic                          clk_i,
    input  logic                          async_rst_ni,

    // result beats from the execution pipeline
    input  logic                          in_valid_i,
    output logic                          in_ready_o,
    input  logic [INSTR_ID_W-1:0]         in_instr_id_i,
    input  sew_e                          in_eew_i,
    input  logic [VADDR_W-1:0]            in_vaddr_i,
    input  logic                          in_store_i,
    input  logic                          in_res_valid_i,
    input  logic [RES_W-1:0]              in_data_i,
    input  logic [RES_W/8-1:0]            in_be_i,
    input  logic                          in_narrow_i,
    input  logic                          in_saturate_i,
    input  logic                          in_signed_i,
    input  logic                          in_done_i,
    output logic                          in_saturated_o,   // valid with the accepted beat

    // register file write port
    output logic                          vreg_wr_valid_o,
    input  logic                          vreg_wr_ready_i,
    output logic [VADDR_W-1:0]            vreg_wr_addr_o,
    output logic [VPORT_W-1:0]            vreg_wr_data_o,
    output logic [VPORT_W/8-1:0]          vreg_wr_be_o,

    // hazard and kill status
    input  logic [(1 << VADDR_W)-1:0]     pending_reads_i,
    input  logic [(1 << INSTR_ID_W)-1:0]  instr_spec_i,
    input  logic [(1 << INSTR_ID_W)-1:0]  instr_killed_i,

    output logic                          done_valid_o,
    output logic [INSTR_ID_W-1:0]         done_id_o
);

    logic [RES_W-1:0]   shift_data;
    logic [RES_W/8-1:0] shift_be;

    pack_if #(
        .VPORT_W    (VPORT_W),
        .VADDR_W    (VADDR_W),
        .INSTR_ID_W (INSTR_ID_W)
    ) pif ();

    result_narrow #(
        .RES_W (RES_W)
    ) u_narrow (
        .eew_i        (in_eew_i),
        .data_i       (in_data_i),
        .be_i         (in_be_i),
        .narrow_i     (in_narrow_i),
        .saturate_i   (in_saturate_i),
        .signed_i     (in_signed_i),
        .shift_data_o (shift_data),
        .shift_be_o   (shift_be),
        .saturated_o  (in_saturated_o)
    );

    pack_stage #(
        .VPORT_W    (VPORT_W),
        .RES_W      (RES_W),
        .VADDR_W    (VADDR_W),
        .INSTR_ID_W (INSTR_ID_W)
    ) u_stage (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .in_valid_i     (in_valid_i),
        .in_ready_o     (in_ready_o),
        .in_instr_id_i  (in_instr_id_i),
        .in_vaddr_i     (in_vaddr_i),
        .in_store_i     (in_store_i),
        .in_res_valid_i (in_res_valid_i),
        .in_narrow_i    (in_narrow_i),
        .in_done_i      (in_done_i),
        .shift_data_i   (shift_data),
        .shift_be_i     (shift_be),
        .pif            (pif)
    );

    vreg_write_ctrl #(
        .VPORT_W    (VPORT_W),
        .VADDR_W    (VADDR_W),
        .INSTR_ID_W (INSTR_ID_W)
    ) u_write (
        .pif             (pif),
        .pending_reads_i (pending_reads_i),
        .instr_spec_i    (instr_spec_i),
        .instr_killed_i  (instr_killed_i),
        .vreg_wr_ready_i (vreg_wr_ready_i),
        .vreg_wr_valid_o (vreg_wr_valid_o),
        .vreg_wr_addr_o  (vreg_wr_addr_o),
        .vreg_wr_data_o  (vreg_wr_data_o),
        .vreg_wr_be_o    (vreg_wr_be_o),
        .done_valid_o    (done_valid_o),
        .done_id_o       (done_id_o)
    );

endmodule

`default_nettype wire

// ==== testbench/vregpack_assert.sv ====
// protocol assertions for the packer
// write port stability, hazard free writes and reset state
`timescale 1ns/1ns
`default_nettype none

module vregpack_assert #(
    parameter int unsigned VPORT_W    = 64,
    parameter int unsigned VADDR_W    = 5,
    parameter int unsigned INSTR_ID_W = 3
) (
    input logic                          clk_i,
    input logic                          async_rst_ni,
    input logic                          in_ready_o,
    input logic                          vreg_wr_valid_o,
    input logic                          vreg_wr_ready_i,
    input logic [VADDR_W-1:0]            vreg_wr_addr_o,
    input logic [VPORT_W-1:0]            vreg_wr_data_o,
    input logic [VPORT_W/8-1:0]          vreg_wr_be_o,
    input logic [(1 << VADDR_W)-1:0]     pending_reads_i,
    input logic [(1 << INSTR_ID_W)-1:0]  instr_spec_i,
    input logic [(1 << INSTR_ID_W)-1:0]  instr_killed_i,
    input logic                          done_valid_o,
    input logic [INSTR_ID_W-1:0]         done_id_o   // id held in the stage
);

    wr_payload_held: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        vreg_wr_valid_o && !vreg_wr_ready_i |=>
            $stable(vreg_wr_addr_o) && $stable(vreg_wr_data_o) && $stable(vreg_wr_be_o))
        else $error("write payload changed under back-pressure");

    // valid only drops when a hazard or kill shows up
    wr_valid_held: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        vreg_wr_valid_o && !vreg_wr_ready_i |=>
            vreg_wr_valid_o || pending_reads_i[vreg_wr_addr_o] ||
            instr_spec_i[done_id_o] || instr_killed_i[done_id_o])
        else $error("write valid dropped without hazard or kill");

    wr_no_hazard: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        vreg_wr_valid_o |-> !pending_reads_i[vreg_wr_addr_o] && !instr_spec_i[done_id_o])
        else $error("write offered while register read or id speculative");

    wr_frees_stage: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        vreg_wr_valid_o && vreg_wr_ready_i |-> in_ready_o)
        else $error("completed write did not free the stage");

    reset_idle: assert property (@(posedge clk_i)
        !async_rst_ni |-> in_ready_o && !vreg_wr_valid_o && !done_valid_o)
        else $error("activity during reset");

endmodule

bind vregpack_top vregpack_assert #(
    .VPORT_W    (VPORT_W),
    .VADDR_W    (VADDR_W),
    .INSTR_ID_W (INSTR_ID_W)
) u_assert (.*);

`default_nettype wire

// ==== testbench/tb_vregpack.sv ====
// testbench for the vector register result packer
// random beats and hazard status, checked against a model of the pack rules
`timescale 1ns/1ns
`default_nettype none

module tb_vregpack import vregpack_pkg::*; ();

    localparam int unsigned VPORT_W    = VPORT_W_DEF;
    localparam int unsigned RES_W      = RES_W_DEF;
    localparam int unsigned VADDR_W    = VADDR_W_DEF;
    localparam int unsigned INSTR_ID_W = INSTR_ID_W_DEF;
    localparam int unsigned NUM_BEATS  = 400;
    localparam int unsigned MAX_CYCLES = NUM_BEATS * 20;
    localparam int unsigned WR_W       = VADDR_W + VPORT_W + VPORT_W / 8;  // addr, data, be

    logic                          clk_i, async_rst_ni;
    logic                          in_valid_i, in_ready_o;
    logic [INSTR_ID_W-1:0]         in_instr_id_i;
    sew_e                          in_eew_i;
    logic [VADDR_W-1:0]            in_vaddr_i;
    logic                          in_store_i, in_res_valid_i, in_done_i;
    logic [RES_W-1:0]              in_data_i;
    logic [RES_W/8-1:0]            in_be_i;
    logic                          in_narrow_i, in_saturate_i, in_signed_i, in_saturated_o;
    logic                          vreg_wr_valid_o, vreg_wr_ready_i;
    logic [VADDR_W-1:0]            vreg_wr_addr_o;
    logic [VPORT_W-1:0]            vreg_wr_data_o;
    logic [VPORT_W/8-1:0]          vreg_wr_be_o;
    logic [(1 << VADDR_W)-1:0]     pending_reads_i;
    logic [(1 << INSTR_ID_W)-1:0]  instr_spec_i, instr_killed_i;
    logic                          done_valid_o;
    logic [INSTR_ID_W-1:0]         done_id_o;

    // reference model of the stage
    logic                  m_valid, m_store, m_done;
    logic [INSTR_ID_W-1:0] m_id;
    logic [VADDR_W-1:0]    m_vaddr;
    logic [VPORT_W-1:0]    m_data;
    logic [VPORT_W/8-1:0]  m_be;
    logic [WR_W-1:0]       exp_wr_q[$];
    logic [INSTR_ID_W-1:0] exp_done_q[$];
    integer                seed = 32'h805e;
    int unsigned           cycle_cnt = 0, beat_cnt = 0, wr_cnt = 0, done_cnt = 0;
    int unsigned           sat_cnt = 0, stall_cnt = 0, kill_cnt = 0;

    vregpack_top dut (.*);

    always #10 clk_i = ~clk_i;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic [VPORT_W-1:0] exp_v,
                             input logic [VPORT_W-1:0] got_v);
        if (exp_v !== got_v) begin
            abort_run($sformatf("[ERROR] %0t %s expected %0h got %0h", $time, name, exp_v, got_v));
        end
    endtask

    // half width value and enables of a narrowing beat
    task automatic narrow_model(input sew_e eew, input logic [RES_W-1:0] d,
                                input logic [RES_W/8-1:0] be, input logic sat_en, input logic sgn,
                                output logic [RES_W/2-1:0] nd, output logic [RES_W/16-1:0] nbe,
                                output logic sat);
        logic [7:0]  lo8, hi8;
        logic [15:0] lo16, hi16;
        int          j;
        nd  = '0;
        nbe = '0;
        sat = 1'b0;
        for (j = 0; j < RES_W / 16 && eew == SEW_16; j++) begin
            lo8          = d[16*j +: 8];
            hi8          = d[16*j+8 +: 8];
            nd[8*j +: 8] = lo8;
            nbe[j]       = be[2*j];
            if (sat_en && (sgn ? hi8 != {8{lo8[7]}} : hi8 != 8'h00)) begin
                nd[8*j +: 8] = !sgn ? 8'hff : (hi8[7] ? 8'h80 : 8'h7f);
                sat          = 1'b1;
            end
        end
        for (j = 0; j < RES_W / 32 && eew == SEW_32; j++) begin
            lo16            = d[32*j +: 16];
            hi16            = d[32*j+16 +: 16];
            nd[16*j +: 16]  = lo16;
            nbe[2*j +: 2]   = {2{be[4*j]}};
            if (sat_en && (sgn ? hi16 != {16{lo16[15]}} : hi16 != 16'h0000)) begin
                nd[16*j +: 16] = !sgn ? 16'hffff : (hi16[15] ? 16'h8000 : 16'h7fff);
                sat            = 1'b1;
            end
        end
    endtask

    // hazard bits come and go with clears frequent enough to end every stall
    task automatic drive_status();
        vreg_wr_ready_i = ($random(seed) & 3) != 0;
        if (($random(seed) & 7) == 0) pending_reads_i[vreg_wr_addr_o] = 1'b1;
        if (($random(seed) & 3) == 0) pending_reads_i = '0;
        if (($random(seed) & 3) == 0) instr_spec_i[{$random(seed)} % 8] = 1'b1;
        if (($random(seed) & 3) == 0) instr_spec_i = '0;
        if (($random(seed) & 7) == 0) instr_killed_i[{$random(seed)} % 8] = 1'b1;
        if (($random(seed) & 3) == 0) instr_killed_i = '0;
    endtask

    task automatic make_beat();
        logic [RES_W-1:0] d;
        int               mode;
        d    = $random(seed);
        mode = $random(seed) & 3;  // 1 sign extended, 2 zero extended, else raw
        in_narrow_i = $random(seed) & 1;
        if (in_narrow_i) in_eew_i = ($random(seed) & 1) ? SEW_32 : SEW_16;
        else in_eew_i = ($random(seed) & 1) ? SEW_8 : SEW_32;
        if (in_eew_i == SEW_16) begin
            if (mode == 1) d = {{8{d[23]}}, d[23:16], {8{d[7]}}, d[7:0]};
            if (mode == 2) d = {8'h00, d[23:16], 8'h00, d[7:0]};
        end else begin
            if (mode == 1) d = {{16{d[15]}}, d[15:0]};
            if (mode == 2) d = {16'h0000, d[15:0]};
        end
        in_data_i      = d;
        in_be_i        = $random(seed);
        in_instr_id_i  = $random(seed);
        in_vaddr_i     = $random(seed);
        in_store_i     = ($random(seed) & 3) == 0;
        in_done_i      = ($random(seed) & 3) == 0;
        in_res_valid_i = ($random(seed) & 7) != 0;
        in_saturate_i  = $random(seed) & 1;
        in_signed_i    = $random(seed) & 1;
    endtask

    always @(posedge clk_i) begin : monitor
        logic                 stall, killed, adv, rdy, sat;
        logic [WR_W-1:0]      wr;
        logic [RES_W/2-1:0]   nd;
        logic [RES_W/16-1:0]  nbe;
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) begin
            abort_run($sformatf("timeout, run not finished after %0d cycles", MAX_CYCLES));
        end else if (!async_rst_ni) begin
            {m_valid, m_store, m_done, m_id, m_vaddr, m_data, m_be} = '0;
        end else begin
            stall  = m_store && (pending_reads_i[m_vaddr] || instr_spec_i[m_id]);
            killed = instr_killed_i[m_id];
            adv    = m_valid && !stall && (!m_store || killed || vreg_wr_ready_i);
            rdy    = !m_valid || adv;
            check_val("in_ready_o", rdy, in_ready_o);
            check_val("vreg_wr_valid_o", m_valid && m_store && !stall && !killed, vreg_wr_valid_o);
            check_val("done_valid_o", adv && m_done, done_valid_o);
            if (m_valid && stall) stall_cnt++;
            if (adv && m_store && killed) kill_cnt++;
            if (adv && m_store && !killed) exp_wr_q.push_back({m_vaddr, m_data, m_be});
            if (adv && m_done) exp_done_q.push_back(m_id);
            if (vreg_wr_valid_o && vreg_wr_ready_i) begin
                if (exp_wr_q.size() == 0) begin
                    abort_run("register file write seen while none was expected");
                end else begin
                    wr = exp_wr_q.pop_front();
                    check_val("vreg_wr_addr_o", wr[VPORT_W+VPORT_W/8 +: VADDR_W], vreg_wr_addr_o);
                    check_val("vreg_wr_data_o", wr[VPORT_W/8 +: VPORT_W], vreg_wr_data_o);
                    check_val("vreg_wr_be_o", wr[VPORT_W/8-1:0], vreg_wr_be_o);
                    wr_cnt++;
                end
            end
            if (done_valid_o && exp_done_q.size() != 0) begin
                check_val("done_id_o", exp_done_q.pop_front(), done_id_o);
                done_cnt++;
            end
            if (in_valid_i && rdy) begin
                narrow_model(in_eew_i, in_data_i, in_be_i, in_saturate_i, in_signed_i,
                             nd, nbe, sat);
                check_val("in_saturated_o", in_narrow_i && sat, in_saturated_o);
                if (in_narrow_i && sat) sat_cnt++;
                {m_id, m_vaddr, m_store, m_done} =
                    {in_instr_id_i, in_vaddr_i, in_store_i, in_done_i};
                if (in_res_valid_i && in_narrow_i) begin
                    m_data = {nd, m_data[VPORT_W-1:RES_W/2]};
                    m_be   = {nbe, m_be[VPORT_W/8-1:RES_W/16]};
                end else if (in_res_valid_i) begin
                    m_data = {in_data_i, m_data[VPORT_W-1:RES_W]};
                    m_be   = {in_be_i, m_be[VPORT_W/8-1:RES_W/8]};
                end
                beat_cnt++;
            end
            if (rdy) m_valid = in_valid_i;
        end
    end

    initial begin : stimulus
        logic accepted;
        clk_i = 1'b0;
        async_rst_ni = 1'b0;
        {in_valid_i, in_instr_id_i, in_vaddr_i, in_store_i, in_res_valid_i} = '0;
        {in_data_i, in_be_i, in_narrow_i, in_saturate_i, in_signed_i, in_done_i} = '0;
        {vreg_wr_ready_i, pending_reads_i, instr_spec_i, instr_killed_i} = '0;
        in_eew_i = SEW_32;
        repeat (5) @(posedge clk_i);
        #2 async_rst_ni = 1'b1;
        for (int n = 0; n < NUM_BEATS; n++) begin
            while (($random(seed) & 3) == 0) begin  // idle gap
                in_valid_i = 1'b0;
                @(posedge clk_i);
                #2 drive_status();
            end
            make_beat();
            in_valid_i = 1'b1;
            do begin
                @(posedge clk_i);
                accepted = in_ready_o;
                #2 drive_status();
            end while (!accepted);
        end
        in_valid_i = 1'b0;
        // drain the stage until every expected write and done is seen
        while (m_valid || exp_wr_q.size() != 0 || exp_done_q.size() != 0) begin
            @(posedge clk_i);
            #2 drive_status();
        end
        $display("%0d beats, %0d writes, %0d done reports", beat_cnt, wr_cnt, done_cnt);
        if (wr_cnt == 0 || done_cnt == 0 || sat_cnt == 0 || stall_cnt == 0 || kill_cnt == 0) begin
            abort_run($sformatf("stimulus missed a behavior: %0d saturated, %0d stalled, %0d killed",
                                sat_cnt, stall_cnt, kill_cnt));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== vregpack.f ====
src/vregpack_pkg.sv
src/pack_if.sv
src/result_narrow.sv
src/pack_stage.sv
src/vreg_write_ctrl.sv
src/vregpack_top.sv
testbench/vregpack_assert.sv
testbench/tb_vregpack.sv

// ==== Bender.yml ====
package:
  name: vregpack

sources:
  - files:
      - src/vregpack_pkg.sv
      - src/pack_if.sv
      - src/result_narrow.sv
      - src/pack_stage.sv
      - src/vreg_write_ctrl.sv
      - src/vregpack_top.sv
  - target: test
    files:
      - testbench/vregpack_assert.sv
      - testbench/tb_vregpack.sv
